// ==== files.f ====
+incdir+.
cap_pkg.sv
wb_pkg.sv
bank_fifo.sv
capture_ctrl.sv
cap_regs.sv
capture_top.sv
tb_capture_top.sv

// ==== tb_capture_top.sv ====
`timescale 1ns/1ps
`include "cap_defines.svh"

module tb_capture_top;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 5;
    localparam int MARGIN_CYCLES = 200;
    localparam int ACK_LIMIT     = 16;    // Cycles to wait for ack
    localparam int N_SAMPLES     = 300;
    localparam int MAX_STEPS     = 64;

    // State codes in enum order
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RUN  = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd2;

    typedef enum logic [1:0] {
        OP_WRITE,                         // Write val to adr
        OP_READ,                          // Read adr, compare with val
        OP_FEED,                          // Feed arg samples from index val
        OP_POP                            // Pop arg words, compare from index val
    } op_e;

    typedef struct packed {
        op_e               op;
        wb_pkg::reg_addr_e adr;
        logic [15:0]       arg;
        logic [31:0]       val;
    } step_t;

    logic                   r_clk;
    logic                   fullish;
    logic                   sample_valid;
    logic [`CAP_DATA_W-1:0] sample_data;
    wb_pkg::wb_req_t        wb_req;
    wb_pkg::wb_rsp_t        wb_rsp;

    logic [`CAP_DATA_W-1:0] samples [N_SAMPLES];
    step_t                  steps [MAX_STEPS];
    int                     n_steps;
    int                     seed;
    int                     n_checks;
    int                     n_errors;
    logic                   table_ready;

    capture_top capture_top_i (
        .r_clk        (r_clk),
        .fullish      (fullish),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp)
    );

    always #(CLK_PERIOD / 2) r_clk = ~r_clk;

    // ======================================================================
    // Helpers
    // ======================================================================

    // STATUS layout: accepted 31:8, flags 6:2 (w_ready on top), state 1:0
    function automatic logic [31:0] status_word(input logic [1:0] state, input int accepted,
                                                input logic w_ready, input logic r_ready,
                                                input logic w_bank, input logic r_bank,
                                                input logic dir);
        return {accepted[23:0], 1'b0, w_ready, r_ready, w_bank, r_bank, dir, state};
    endfunction

    task automatic add_step(input op_e op, input wb_pkg::reg_addr_e adr, input int arg,
                            input logic [31:0] val);
        steps[n_steps] = '{op: op, adr: adr, arg: arg[15:0], val: val};
        n_steps++;
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Starts and ends 2 ns after a rising edge, stb held through the ack cycle
    task automatic bus_transfer(input logic we, input wb_pkg::reg_addr_e adr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        rdata  = '0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
        do begin
            @(posedge r_clk);
            #2;
            waited++;
        end while (!wb_rsp.ack && waited < ACK_LIMIT);
        if (wb_rsp.ack) begin
            rdata = wb_rsp.dat_r;
        end else begin
            n_errors++;
            $display("bus error at %0t ns: no ack for register %0d", $time, adr);
        end
        @(posedge r_clk);
        #2;
        // Request still held here, ack must already be gone
        n_checks++;
        assert (wb_rsp.ack === 1'b0) else begin
            n_errors++;
            $display("bus error at %0t ns: ack still high one cycle later on register %0d",
                     $time, adr);
        end
        wb_req = '0;
    endtask

    task automatic wb_write(input wb_pkg::reg_addr_e adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_transfer(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input wb_pkg::reg_addr_e adr, output logic [31:0] data);
        bus_transfer(1'b0, adr, '0, data);
    endtask

    task automatic feed_samples(input int count, input int first);
        for (int i = 0; i < count; i++) begin
            sample_valid = 1'b1;
            sample_data  = samples[first + i];
            @(posedge r_clk);
            #2;
        end
        sample_valid = 1'b0;
        sample_data  = '0;
    endtask

    task automatic pop_and_compare(input int count, input int first);
        logic [31:0] data;
        for (int i = 0; i < count; i++) begin
            wb_read(wb_pkg::REG_DATA, data);
            check_word($sformatf("DATA word for sample %0d", first + i), data,
                       {16'h0, samples[first + i]});
        end
    endtask

    // ======================================================================
    // Test table
    // ======================================================================

    task automatic build_table;
        n_steps = 0;
        // Reset state, a DATA read on an empty buffer pops nothing
        add_step(OP_READ, wb_pkg::REG_STATUS, 0, status_word(ST_IDLE, 0, 1, 0, 0, 0, 0));
        add_step(OP_READ, wb_pkg::REG_OVERRUN, 0, 32'd0);
        add_step(OP_READ, wb_pkg::REG_DATA, 0, 32'd0);
        add_step(OP_READ, wb_pkg::REG_STATUS, 0, status_word(ST_IDLE, 0, 1, 0, 0, 0, 0));
        // Bank handoff at the 128th word
        add_step(OP_WRITE, wb_pkg::REG_CTRL, 0, 32'h0000_0201);
        add_step(OP_READ, wb_pkg::REG_CTRL, 0, 32'h0000_0200);
        add_step(OP_FEED, wb_pkg::REG_CTRL, 127, 0);
        add_step(OP_READ, wb_pkg::REG_STATUS, 0, status_word(ST_RUN, 127, 1, 0, 0, 0, 0));
        add_step(OP_FEED, wb_pkg::REG_CTRL, 1, 127);
        add_step(OP_READ, wb_pkg::REG_STATUS, 0, status_word(ST_RUN, 128, 1, 1, 1, 0, 0));
        // Data order
        add_step(OP_FEED, wb_pkg::REG_CTRL, 128, 128);
        add_step(OP_READ, wb_pkg::REG_STATUS, 0, status_word(ST_DONE, 256, 0, 1, 0, 0, 1));
        add_step(OP_POP, wb_pkg::REG_DATA, 256, 0);
        add_step(OP_READ, wb_pkg::REG_STATUS, 0, status_word(ST_DONE, 256, 1, 0, 0, 0, 0));
        add_step(OP_READ, wb_pkg::REG_DATA, 0, 32'd0);
        // Full stop, the last 44 of 300 are dropped
        add_step(OP_WRITE, wb_pkg::REG_CTRL, 0, 32'h0000_0401);
        add_step(OP_FEED, wb_pkg::REG_CTRL, 300, 0);
        add_step(OP_READ, wb_pkg::REG_STATUS, 0, status_word(ST_RUN, 256, 0, 1, 0, 0, 1));
        add_step(OP_READ, wb_pkg::REG_OVERRUN, 0, 32'd44);
        // Draining one bank frees it; two rounds to reach 4 banks
        add_step(OP_POP, wb_pkg::REG_DATA, 128, 0);
        add_step(OP_READ, wb_pkg::REG_STATUS, 0, status_word(ST_RUN, 256, 1, 1, 0, 1, 1));
        add_step(OP_FEED, wb_pkg::REG_CTRL, 128, 0);
        add_step(OP_READ, wb_pkg::REG_STATUS, 0, status_word(ST_RUN, 384, 0, 1, 1, 1, 1));
        add_step(OP_POP, wb_pkg::REG_DATA, 128, 128);
        add_step(OP_FEED, wb_pkg::REG_CTRL, 128, 128);
        add_step(OP_READ, wb_pkg::REG_STATUS, 0, status_word(ST_DONE, 512, 0, 1, 0, 0, 1));
        add_step(OP_READ, wb_pkg::REG_OVERRUN, 0, 32'd44);
        add_step(OP_FEED, wb_pkg::REG_CTRL, 20, 0);   // Ignored once done
        add_step(OP_READ, wb_pkg::REG_STATUS, 0, status_word(ST_DONE, 512, 0, 1, 0, 0, 1));
        add_step(OP_READ, wb_pkg::REG_OVERRUN, 0, 32'd44);
        // Flush empties the buffer, counts stay
        add_step(OP_WRITE, wb_pkg::REG_CTRL, 0, 32'h0000_0002);
        add_step(OP_READ, wb_pkg::REG_STATUS, 0, status_word(ST_DONE, 512, 1, 0, 0, 0, 0));
        add_step(OP_READ, wb_pkg::REG_DATA, 0, 32'd0);
    endtask

    // ======================================================================
    // Main sequence and watchdog
    // ======================================================================

    initial begin
        step_t       step;
        logic [31:0] rdata;
        r_clk        = 1'b0;
        fullish      = 1'b1;
        sample_valid = 1'b0;
        sample_data  = '0;
        wb_req       = '0;
        n_checks     = 0;
        n_errors     = 0;
        table_ready  = 1'b0;
        seed         = 6;
        for (int i = 0; i < N_SAMPLES; i++) begin
            samples[i] = 16'($random(seed));
        end
        build_table();
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge r_clk);
        #2;
        fullish = 1'b0;

        for (int i = 0; i < n_steps; i++) begin
            step = steps[i];
            case (step.op)
                OP_WRITE: wb_write(step.adr, step.val);
                OP_READ: begin
                    wb_read(step.adr, rdata);
                    check_word($sformatf("step %0d, register %0d", i, step.adr), rdata,
                               step.val);
                end
                OP_FEED: feed_samples(step.arg, step.val);
                default: pop_and_compare(step.arg, step.val);
            endcase
        end

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Budget is the cycle count of the table plus reset and a margin
    initial begin
        int cycles;
        wait (table_ready);
        cycles = RESET_CYCLES + MARGIN_CYCLES;
        for (int i = 0; i < n_steps; i++) begin
            case (steps[i].op)
                OP_FEED: cycles += steps[i].arg;
                OP_POP:  cycles += 2 * steps[i].arg;    // Two cycles per bus read
                default: cycles += 2;
            endcase
        end
        #(cycles * CLK_PERIOD);
        $display("timeout: the tests did not complete within %0d clock cycles", cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== capture_top.sv ====
`timescale 1ns/1ps
`include "cap_defines.svh"

module capture_top (
    input  logic                   r_clk,
    input  logic                   fullish,
    input  logic                   sample_valid,
    input  logic [`CAP_DATA_W-1:0] sample_data,
    input  wb_pkg::wb_req_t        wb_req,
    output wb_pkg::wb_rsp_t        wb_rsp
);

    cap_pkg::cap_cfg_t      cfg;
    cap_pkg::cap_status_t   status;
    cap_pkg::fifo_flags_t   flags;
    logic                   wr_en;
    logic                   rd_en;
    logic                   flush;
    logic [`CAP_DATA_W-1:0] wr_data;
    logic [`CAP_DATA_W-1:0] rd_data;

    // Host side
    cap_regs cap_regs_i (
        .r_clk   (r_clk),
        .fullish (fullish),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .cfg     (cfg),
        .status  (status),
        .flags   (flags),
        .rd_en   (rd_en),
        .rd_data (rd_data)
    );

    // Stream side
    capture_ctrl capture_ctrl_i (
        .r_clk        (r_clk),
        .fullish      (fullish),
        .cfg          (cfg),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .flags        (flags),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .flush        (flush),
        .status       (status)
    );

    bank_fifo bank_fifo_i (
        .r_clk   (r_clk),
        .fullish (fullish),
        .flush   (flush),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .flags   (flags)
    );

endmodule

// ==== cap_regs.sv ====
`timescale 1ns/1ps
`include "cap_defines.svh"

module cap_regs (
    input  logic                   r_clk,
    input  logic                   fullish,
    input  wb_pkg::wb_req_t        wb_req,
    output wb_pkg::wb_rsp_t        wb_rsp,
    output cap_pkg::cap_cfg_t      cfg,
    input  cap_pkg::cap_status_t   status,
    input  cap_pkg::fifo_flags_t   flags,
    output logic                   rd_en,
    input  logic [`CAP_DATA_W-1:0] rd_data
);

    wb_pkg::reg_addr_e     addr;
    logic                  req_new;
    logic                  ctrl_wr;
    logic                  ack_q;
    logic                  arm_q;
    logic                  flush_q;
    logic [`CAP_LEN_W-1:0] len_q;
    logic [31:0]           rd_mux;

    // ======================================================================
    // Bus handshake
    // ======================================================================

    assign addr    = wb_pkg::reg_addr_e'(wb_req.adr);
    assign req_new = wb_req.cyc && wb_req.stb && !ack_q;     // Not yet acked
    assign ctrl_wr = req_new && wb_req.we && (addr == wb_pkg::REG_CTRL);

    always_ff @(posedge r_clk or posedge fullish) begin
        if (fullish) begin
            ack_q   <= 1'b0;
            arm_q   <= 1'b0;
            flush_q <= 1'b0;
            len_q   <= '0;
        end else begin
            ack_q   <= req_new;                              // One cycle only
            arm_q   <= ctrl_wr && wb_req.dat_w[0];
            flush_q <= ctrl_wr && wb_req.dat_w[1];
            if (ctrl_wr) begin
                len_q <= wb_req.dat_w[8 +: `CAP_LEN_W];
            end
        end
    end

    // Pulses line up with the ack cycle
    assign cfg = '{
        arm:       arm_q,
        flush:     flush_q,
        len_banks: len_q
    };

    // ======================================================================
    // Read path
    // ======================================================================

    always_comb begin
        rd_mux = '0;
        case (addr)
            wb_pkg::REG_CTRL: begin
                rd_mux[8 +: `CAP_LEN_W] = len_q;
            end
            wb_pkg::REG_STATUS: begin
                rd_mux = {status.accepted, 1'b0, flags, status.state};
            end
            wb_pkg::REG_DATA: begin
                if (flags.r_ready) begin
                    rd_mux[`CAP_DATA_W-1:0] = rd_data;       // Empty reads as zero
                end
            end
            wb_pkg::REG_OVERRUN: begin
                rd_mux[15:0] = status.overrun;
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = ack_q ? rd_mux : '0;

    // Head leaves the buffer at the end of the ack cycle
    assign rd_en = ack_q && wb_req.cyc && wb_req.stb && !wb_req.we &&
                   (addr == wb_pkg::REG_DATA) && flags.r_ready;

    // ack only rises while the master still holds its request
    a_ack_req : assert property (@(posedge r_clk) disable iff (fullish)
        $rose(ack_q) |-> wb_req.cyc && wb_req.stb);

endmodule

// ==== capture_ctrl.sv ====
`timescale 1ns/1ps
`include "cap_defines.svh"

module capture_ctrl (
    input  logic                   r_clk,
    input  logic                   fullish,
    input  cap_pkg::cap_cfg_t      cfg,
    input  logic                   sample_valid,
    input  logic [`CAP_DATA_W-1:0] sample_data,
    input  cap_pkg::fifo_flags_t   flags,
    output logic                   wr_en,
    output logic [`CAP_DATA_W-1:0] wr_data,
    output logic                   flush,
    output cap_pkg::cap_status_t   status
);

    cap_pkg::cap_status_t st_q;
    logic [23:0]          acc_next;
    logic [23:0]          target;    // len_banks whole banks
    logic                 running;
    logic                 drop;

    // ======================================================================
    // Sample gating
    // ======================================================================

    // Arming restarts the buffer as well
    assign flush = cfg.arm || cfg.flush;

    assign running = (st_q.state == cap_pkg::CAP_RUN);

    assign wr_en   = running && sample_valid && flags.w_ready && !flush;
    assign drop    = running && sample_valid && !flags.w_ready && !flush;
    assign wr_data = sample_data;

    assign acc_next = st_q.accepted + 1'b1;
    assign target   = 24'({cfg.len_banks, {(`CAP_DEPTH_LOG2-1){1'b0}}});

    // ======================================================================
    // State and counters
    // ======================================================================

    always_ff @(posedge r_clk or posedge fullish) begin
        if (fullish) begin
            st_q <= '0;                                  // CAP_IDLE, counts clear
        end else if (cfg.arm) begin
            st_q.state    <= cap_pkg::CAP_RUN;
            st_q.accepted <= '0;
            st_q.overrun  <= '0;
        end else if (running) begin
            if (wr_en) begin
                st_q.accepted <= acc_next;
                if (acc_next == target) begin
                    st_q.state <= cap_pkg::CAP_DONE;     // Last bank filled
                end
            end
            // Stream has no back-pressure, count what is lost
            if (drop && st_q.overrun != '1) begin
                st_q.overrun <= st_q.overrun + 1'b1;
            end
        end
    end

    assign status = st_q;

    // Writes belong to a running capture that has not yet reached its length
    a_wr_in_run : assert property (@(posedge r_clk) disable iff (fullish)
        wr_en |-> (st_q.state == cap_pkg::CAP_RUN) && (st_q.accepted < target));

endmodule

// ==== bank_fifo.sv ====
`timescale 1ns/1ps
`include "cap_defines.svh"

module bank_fifo (
    input  logic                   r_clk,
    input  logic                   fullish,
    input  logic                   flush,
    input  logic                   wr_en,
    input  logic                   rd_en,
    input  logic [`CAP_DATA_W-1:0] wr_data,
    output logic [`CAP_DATA_W-1:0] rd_data,
    output cap_pkg::fifo_flags_t   flags
);

    localparam int DEPTH = 1 << `CAP_DEPTH_LOG2;

    logic [`CAP_DATA_W-1:0]     mem [DEPTH];
    logic [`CAP_DEPTH_LOG2-1:0] w_ptr;
    logic [`CAP_DEPTH_LOG2-1:0] r_ptr;
    logic [1:0]                 w_qtr;
    logic [1:0]                 r_qtr;
    logic                       w_bank;
    logic                       r_bank;
    logic                       dir_q;
    logic                       w_ready;
    logic                       r_ready;
    logic                       do_wr;
    logic                       do_rd;

    // ======================================================================
    // Bank and quarter decode
    // ======================================================================

    assign w_bank = w_ptr[`CAP_DEPTH_LOG2-1];
    assign r_bank = r_ptr[`CAP_DEPTH_LOG2-1];
    assign w_qtr  = w_ptr[`CAP_DEPTH_LOG2-1 -: 2];
    assign r_qtr  = r_ptr[`CAP_DEPTH_LOG2-1 -: 2];

    // Same bank is only shared in the direction dir allows
    assign w_ready = (w_bank != r_bank) || !dir_q;
    assign r_ready = (r_bank != w_bank) || dir_q;

    assign do_wr = wr_en && w_ready && !flush;   // Flush wins
    assign do_rd = rd_en && r_ready && !flush;

    // ======================================================================
    // Storage and pointers
    // ======================================================================

    always_ff @(posedge r_clk) begin
        if (do_wr) begin
            mem[w_ptr] <= wr_data;
        end
    end

    assign rd_data = mem[r_ptr];                 // Head word, no read latency

    always_ff @(posedge r_clk or posedge fullish) begin
        if (fullish) begin
            w_ptr <= '0;
            r_ptr <= '0;
        end else if (flush) begin
            w_ptr <= '0;
            r_ptr <= '0;
        end else begin
            if (do_wr) begin
                w_ptr <= w_ptr + 1'b1;
            end
            if (do_rd) begin
                r_ptr <= r_ptr + 1'b1;
            end
        end
    end

    // Direction flag
    // Writer one quarter behind the reader means the buffer is nearly full,
    // reader one quarter behind the writer means it is draining
    always_ff @(posedge r_clk or posedge fullish) begin
        if (fullish) begin
            dir_q <= 1'b0;
        end else if (flush) begin
            dir_q <= 1'b0;
        end else if (w_qtr + 2'd1 == r_qtr) begin
            dir_q <= 1'b1;
        end else if (r_qtr + 2'd1 == w_qtr) begin
            dir_q <= 1'b0;
        end
    end

    assign flags = '{
        w_ready: w_ready,
        r_ready: r_ready,
        w_bank:  w_bank,
        r_bank:  r_bank,
        dir:     dir_q
    };

    // ======================================================================
    // Checks on the two clients
    // ======================================================================

    a_wr_ready : assert property (@(posedge r_clk) disable iff (fullish)
        wr_en |-> w_ready);

    a_rd_ready : assert property (@(posedge r_clk) disable iff (fullish)
        rd_en |-> r_ready);

endmodule

// ==== wb_pkg.sv ====
`include "cap_defines.svh"

package wb_pkg;

    // Master to slave, held until ack
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`CAP_ADDR_W-1:0] adr;
        logic [31:0]            dat_w;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;              // Valid with ack
    } wb_rsp_t;

    // Word addresses of the register block
    typedef enum logic [`CAP_ADDR_W-1:0] {
        REG_CTRL    = 0,
        REG_STATUS  = 1,
        REG_DATA    = 2,                 // Read pops the buffer head
        REG_OVERRUN = 3
    } reg_addr_e;

endpackage

// ==== cap_pkg.sv ====
`include "cap_defines.svh"

package cap_pkg;

    // ======================================================================
    // Capture controller
    // ======================================================================

    typedef enum logic [1:0] {
        CAP_IDLE = 2'd0,
        CAP_RUN  = 2'd1,
        CAP_DONE = 2'd2                  // Length target reached
    } cap_state_e;

    // Control from the register block
    typedef struct packed {
        logic                  arm;      // One-cycle pulse
        logic                  flush;    // One-cycle pulse
        logic [`CAP_LEN_W-1:0] len_banks;
    } cap_cfg_t;

    typedef struct packed {
        cap_state_e  state;
        logic [23:0] accepted;           // Samples written this capture
        logic [15:0] overrun;            // Saturates at all ones
    } cap_status_t;

    // ======================================================================
    // Banked buffer
    // ======================================================================

    typedef struct packed {
        logic w_ready;
        logic r_ready;
        logic w_bank;
        logic r_bank;
        logic dir;                       // High means nearly full
    } fifo_flags_t;

endpackage

// ==== cap_defines.svh ====
`ifndef CAP_DEFINES_SVH
`define CAP_DEFINES_SVH

// ==========================================================================
// Sample capture sizing
// ==========================================================================

// Width of one stream sample
`define CAP_DATA_W      16

// Buffer holds 2**CAP_DEPTH_LOG2 words, half per bank
`define CAP_DEPTH_LOG2  8

// Capture length, counted in whole banks
`define CAP_LEN_W       8

// Wishbone word address width
`define CAP_ADDR_W      2

`endif
